// ==== logic/id_pkg.sv ====
// Decode and issue stage definitions
// Shared widths, RV32I opcodes, select encodings and the control,
// ALU and memory request structs used across the stage
`default_nettype none

package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  // Supported major opcodes
  localparam opcode_t OPC_OP     = 7'h33;
  localparam opcode_t OPC_OP_IMM = 7'h13;
  localparam opcode_t OPC_LUI    = 7'h37;
  localparam opcode_t OPC_AUIPC  = 7'h17;
  localparam opcode_t OPC_LOAD   = 7'h03;
  localparam opcode_t OPC_STORE  = 7'h23;
  localparam opcode_t OPC_BRANCH = 7'h63;
  localparam opcode_t OPC_JAL    = 7'h6f;
  localparam opcode_t OPC_JALR   = 7'h67;

  // No compressed support so the PC always steps by a full word
  localparam word_t INSTR_INCR = 32'd4;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Comparisons for conditional branches
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic [1:0] {LSU_WORD, LSU_HALF, LSU_BYTE} lsu_type_e;

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  // Decoded control of the instruction in the stage
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    logic       lsu_req;
    logic       lsu_we;
    lsu_type_e  lsu_type;
    logic       lsu_sign_ext;
    logic       branch;
    logic       jump;
    logic       illegal;
  } id_ctrl_t;

  // Request to the external ALU
  typedef struct packed {
    alu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  // Request to the load/store unit
  typedef struct packed {
    logic      req;
    logic      we;
    lsu_type_e data_type;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

// ==== logic/id_decoder.sv ====
// Instruction decoder
// Maps opcode, funct3 and funct7 to the ALU operator, operand selects and
// memory controls, and flags unsupported encodings as illegal
`default_nettype none

module id_decoder import id_pkg::*; (
  input  word_t     instr_rdata_i,
  input  logic      instr_first_cycle_i,
  output id_ctrl_t  ctrl_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  always_comb begin
    ctrl_o              = '0;
    ctrl_o.alu_op       = ALU_ADD;
    ctrl_o.op_a_sel     = OP_A_REG_A;
    ctrl_o.op_b_sel     = OP_B_IMM;
    ctrl_o.imm_b_sel    = IMM_B_I;
    ctrl_o.lsu_type     = LSU_WORD;

    unique case (opcode)
      //////////////////////////////////////////////////////////
      // Arithmetic and logic
      //////////////////////////////////////////////////////////
      OPC_OP: begin
        ctrl_o.op_b_sel = OP_B_REG_B;
        ctrl_o.rf_we    = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:         ctrl_o.illegal = 1'b1;
        endcase
      end

      OPC_OP_IMM: begin
        ctrl_o.rf_we = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = (funct7 != 7'h00);
          end
          default: begin
            // funct7 picks a logical or arithmetic right shift
            ctrl_o.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      OPC_LUI: begin
        ctrl_o.op_a_sel  = OP_A_ZERO;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end

      OPC_AUIPC: begin
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end

      //////////////////////////////////////////////////////////
      // Memory access at rs1 plus offset
      //////////////////////////////////////////////////////////
      OPC_LOAD, OPC_STORE: begin
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.lsu_we       = (opcode == OPC_STORE);
        ctrl_o.rf_we        = (opcode == OPC_LOAD);
        ctrl_o.imm_b_sel    = (opcode == OPC_STORE) ? IMM_B_S : IMM_B_I;
        ctrl_o.lsu_sign_ext = ~funct3[2];
        unique case (funct3[1:0])
          2'b00:   ctrl_o.lsu_type = LSU_BYTE;
          2'b01:   ctrl_o.lsu_type = LSU_HALF;
          2'b10:   ctrl_o.lsu_type = LSU_WORD;
          default: ctrl_o.illegal  = 1'b1;
        endcase
        // Unsigned variants exist for loads of bytes and halves only
        if (funct3[2] && (opcode == OPC_STORE || funct3[1])) begin
          ctrl_o.illegal = 1'b1;
        end
      end

      //////////////////////////////////////////////////////////
      // Control transfer
      //////////////////////////////////////////////////////////
      OPC_BRANCH: begin
        ctrl_o.branch = 1'b1;
        if (instr_first_cycle_i) begin
          // Compare rs1 against rs2
          ctrl_o.op_b_sel = OP_B_REG_B;
          unique case (funct3)
            3'b000:  ctrl_o.alu_op  = ALU_EQ;
            3'b001:  ctrl_o.alu_op  = ALU_NE;
            3'b100:  ctrl_o.alu_op  = ALU_LT;
            3'b101:  ctrl_o.alu_op  = ALU_GE;
            3'b110:  ctrl_o.alu_op  = ALU_LTU;
            3'b111:  ctrl_o.alu_op  = ALU_GEU;
            default: ctrl_o.illegal = 1'b1;
          endcase
        end else begin
          // Branch target
          ctrl_o.op_a_sel  = OP_A_CURRPC;
          ctrl_o.imm_b_sel = IMM_B_B;
          ctrl_o.illegal   = (funct3[2:1] == 2'b01);
        end
      end

      OPC_JAL, OPC_JALR: begin
        ctrl_o.jump  = 1'b1;
        ctrl_o.rf_we = 1'b1;
        if (instr_first_cycle_i) begin
          ctrl_o.op_a_sel  = (opcode == OPC_JAL) ? OP_A_CURRPC : OP_A_REG_A;
          ctrl_o.imm_b_sel = (opcode == OPC_JAL) ? IMM_B_J : IMM_B_I;
        end else begin
          // Link value
          ctrl_o.op_a_sel  = OP_A_CURRPC;
          ctrl_o.imm_b_sel = IMM_B_INCR_PC;
        end
        ctrl_o.illegal = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // An illegal instruction has no side effects
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.lsu_req = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jump    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_operand_mux.sv ====
// Operand selection
// Extracts the immediates and selects ALU operands A and B and the store data
`default_nettype none

module id_operand_mux import id_pkg::*; (
  input  word_t    instr_rdata_i,
  input  word_t    pc_id_i,
  input  word_t    rf_rdata_a_i,
  input  word_t    rf_rdata_b_i,
  input  id_ctrl_t ctrl_i,
  output alu_req_t alu_o,
  output word_t    lsu_wdata_o
);

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_b_type;
  word_t imm_u_type;
  word_t imm_j_type;
  word_t imm_b;

  ////////////////////////////////////////////////////////////
  // Immediates with the sign taken from bit 31
  ////////////////////////////////////////////////////////////
  assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_type = {instr_rdata_i[31:12], 12'h000};
  assign imm_j_type = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};

  always_comb begin
    unique case (ctrl_i.imm_b_sel)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_B:       imm_b = imm_b_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_J:       imm_b = imm_j_type;
      default:       imm_b = INSTR_INCR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////
  always_comb begin
    unique case (ctrl_i.op_a_sel)
      OP_A_REG_A:  alu_o.operand_a = rf_rdata_a_i;
      OP_A_CURRPC: alu_o.operand_a = pc_id_i;
      default:     alu_o.operand_a = '0;
    endcase
  end

  assign alu_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;
  assign alu_o.operator  = ctrl_i.alu_op;

  // Stores always write rs2
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== logic/id_issue_ctrl.sv ====
// Issue control
// Two-state FSM that stalls loads, stores, taken branches and jumps, and
// gates the register write, memory request and PC set with completion
`default_nettype none

module id_issue_ctrl import id_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     instr_valid_i,
  input  logic     branch_decision_i,
  input  logic     lsu_valid_i,
  input  id_ctrl_t ctrl_i,
  output logic     instr_first_cycle_o,
  output logic     lsu_req_o,
  output logic     rf_we_o,
  output logic     pc_set_o,
  output logic     instr_done_o,
  output logic     illegal_insn_o
);

  id_fsm_e fsm_q, fsm_d;
  logic    branch_set_d, branch_set_q;
  logic    stall_mem, stall_branch, stall_jump;
  logic    multicycle_done;

  assign instr_first_cycle_o = instr_valid_i & (fsm_q == FIRST_CYCLE);

  // Only a memory access waits for the LSU response to finish
  assign multicycle_done = ctrl_i.lsu_req ? lsu_valid_i : 1'b1;

  // Stall the first cycle of a memory access and then until it returns
  assign stall_mem = instr_valid_i & ctrl_i.lsu_req & (instr_first_cycle_o | ~lsu_valid_i);

  ////////////////////////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    fsm_d        = fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;

    if (instr_valid_i) begin
      unique case (fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu_req) begin
            fsm_d = MULTI_CYCLE;
          end else if (ctrl_i.branch) begin
            // Taken branch needs a second cycle for the target
            fsm_d        = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            // Link value follows in the second cycle
            fsm_d      = MULTI_CYCLE;
            stall_jump = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            fsm_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q        <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      fsm_q        <= fsm_d;
      branch_set_q <= branch_set_d;
    end
  end

  assign instr_done_o   = instr_valid_i & ~(stall_mem | stall_branch | stall_jump);
  assign rf_we_o        = ctrl_i.rf_we & instr_done_o;
  assign lsu_req_o      = ctrl_i.lsu_req & instr_first_cycle_o;
  assign illegal_insn_o = instr_valid_i & ctrl_i.illegal;

  // Jumps redirect in cycle 1 and taken branches one cycle later
  assign pc_set_o = instr_valid_i & (branch_set_q | (instr_first_cycle_o & ctrl_i.jump));

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
// Instruction decode and issue stage
// Decodes one RV32I instruction, drives the ALU and LSU requests and
// sequences multicycle instructions for a two-stage core
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Fetch side
  input  logic      instr_valid_i,
  input  word_t     instr_rdata_i,
  input  word_t     pc_id_i,
  output logic      instr_done_o,
  output logic      pc_set_o,
  output logic      illegal_insn_o,

  // Register file
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_o,

  // Execute
  output alu_req_t  alu_o,
  input  logic      branch_decision_i,
  output lsu_req_t  lsu_o,
  input  logic      lsu_valid_i
);

  id_ctrl_t ctrl;
  logic     instr_first_cycle;
  logic     lsu_req;
  word_t    lsu_wdata;

  id_decoder u_decoder (
    .instr_rdata_i       (instr_rdata_i),
    .instr_first_cycle_i (instr_first_cycle),
    .ctrl_o              (ctrl),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_waddr_o          (rf_waddr_o)
  );

  id_operand_mux u_operand_mux (
    .instr_rdata_i (instr_rdata_i),
    .pc_id_i       (pc_id_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .ctrl_i        (ctrl),
    .alu_o         (alu_o),
    .lsu_wdata_o   (lsu_wdata)
  );

  id_issue_ctrl u_issue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .branch_decision_i   (branch_decision_i),
    .lsu_valid_i         (lsu_valid_i),
    .ctrl_i              (ctrl),
    .instr_first_cycle_o (instr_first_cycle),
    .lsu_req_o           (lsu_req),
    .rf_we_o             (rf_we_o),
    .pc_set_o            (pc_set_o),
    .instr_done_o        (instr_done_o),
    .illegal_insn_o      (illegal_insn_o)
  );

  // Memory request fields
  assign lsu_o.req       = lsu_req;
  assign lsu_o.we        = ctrl.lsu_we;
  assign lsu_o.data_type = ctrl.lsu_type;
  assign lsu_o.sign_ext  = ctrl.lsu_sign_ext;
  assign lsu_o.wdata     = lsu_wdata;

endmodule

`default_nettype wire

// ==== sim/tb_id_stage.sv ====
// Testbench for the decode and issue stage
// Random RV32I instructions with random operands, branch outcomes and memory
// latencies, checked cycle by cycle against a reference model
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RESET_CYCLES     = 16;
  localparam int          NUM_TRANS        = 400;
  localparam int          CYCLE_LIMIT      = RESET_CYCLES + NUM_TRANS * 10;
  localparam int          MAX_INSTR_CYCLES = 12;
  localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid_i;
  word_t     instr_rdata_i;
  word_t     pc_id_i;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  logic      branch_decision_i;
  logic      lsu_valid_i;
  logic      instr_done_o;
  logic      pc_set_o;
  logic      illegal_insn_o;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  reg_addr_t rf_waddr_o;
  logic      rf_we_o;
  alu_req_t  alu_o;
  lsu_req_t  lsu_o;

  logic [31:0] lfsr_state = 32'h5e48;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  string       test_name;

  // Model prediction for the instruction in the stage
  logic        m_illegal;
  logic        m_we;
  logic        m_mem;
  logic        m_store;
  logic        m_branch;
  logic        m_taken;
  logic        m_jump;
  int          m_cycles;
  alu_op_e     m_op;
  word_t       m_a;
  word_t       m_b;
  word_t       m_a2;
  word_t       m_b2;
  lsu_type_e   m_type;
  logic        m_sext;

  id_stage uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_rdata_i     (instr_rdata_i),
    .pc_id_i           (pc_id_i),
    .instr_done_o      (instr_done_o),
    .pc_set_o          (pc_set_o),
    .illegal_insn_o    (illegal_insn_o),
    .rf_raddr_a_o      (rf_raddr_a_o),
    .rf_raddr_b_o      (rf_raddr_b_o),
    .rf_rdata_a_i      (rf_rdata_a_i),
    .rf_rdata_b_i      (rf_rdata_b_i),
    .rf_waddr_o        (rf_waddr_o),
    .rf_we_o           (rf_we_o),
    .alu_o             (alu_o),
    .branch_decision_i (branch_decision_i),
    .lsu_o             (lsu_o),
    .lsu_valid_i       (lsu_valid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Watchdog on the total run length
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e compare_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_EQ;
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LT;
      3'd5:    return ALU_GE;
      3'd6:    return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  task automatic predict_instr(input int lat);
    opcode_t    opc;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    opc   = instr_rdata_i[6:0];
    f3    = instr_rdata_i[14:12];
    f7    = instr_rdata_i[31:25];
    imm_i = 32'($signed(instr_rdata_i[31:20]));
    imm_s = 32'($signed({instr_rdata_i[31:25], instr_rdata_i[11:7]}));
    imm_b = 32'($signed({instr_rdata_i[31], instr_rdata_i[7], instr_rdata_i[30:25],
                         instr_rdata_i[11:8], 1'b0}));
    imm_u = {instr_rdata_i[31:12], 12'h000};
    imm_j = 32'($signed({instr_rdata_i[31], instr_rdata_i[19:12], instr_rdata_i[20],
                         instr_rdata_i[30:21], 1'b0}));
    m_illegal = 1'b0;
    m_we      = 1'b0;
    m_mem     = 1'b0;
    m_store   = 1'b0;
    m_branch  = 1'b0;
    m_jump    = 1'b0;
    m_op      = ALU_ADD;
    m_a       = rf_rdata_a_i;
    m_b       = imm_i;
    m_a2      = pc_id_i;
    m_b2      = 32'd4;
    m_type    = (f3[1:0] == 2'd0) ? LSU_BYTE : (f3[1:0] == 2'd1) ? LSU_HALF : LSU_WORD;
    m_sext    = ~f3[2];
    case (opc)
      OPC_OP: begin
        m_we      = 1'b1;
        m_b       = rf_rdata_b_i;
        m_op      = arith_op(f3, f7[5]);
        m_illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      OPC_OP_IMM: begin
        m_we = 1'b1;
        m_op = arith_op(f3, f3 == 3'd5 && f7[5]);
        if (f3 == 3'd1) begin
          m_illegal = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          m_illegal = (f7 != 7'h00) && (f7 != 7'h20);
        end
      end
      OPC_LUI: begin
        m_we = 1'b1;
        m_a  = '0;
        m_b  = imm_u;
      end
      OPC_AUIPC: begin
        m_we = 1'b1;
        m_a  = pc_id_i;
        m_b  = imm_u;
      end
      OPC_LOAD: begin
        m_mem     = 1'b1;
        m_we      = 1'b1;
        m_illegal = (f3 == 3'd3) || (f3 >= 3'd6);
      end
      OPC_STORE: begin
        m_mem     = 1'b1;
        m_store   = 1'b1;
        m_b       = imm_s;
        m_illegal = (f3 > 3'd2);
      end
      OPC_BRANCH: begin
        m_branch  = 1'b1;
        m_b       = rf_rdata_b_i;
        m_b2      = imm_b;
        m_op      = compare_op(f3);
        m_illegal = (f3 == 3'd2) || (f3 == 3'd3);
      end
      OPC_JAL: begin
        m_jump = 1'b1;
        m_we   = 1'b1;
        m_a    = pc_id_i;
        m_b    = imm_j;
      end
      OPC_JALR: begin
        m_jump    = 1'b1;
        m_we      = 1'b1;
        m_illegal = (f3 != 3'd0);
      end
      default: m_illegal = 1'b1;
    endcase
    // Illegal instructions finish at once without side effects
    if (m_illegal) begin
      m_we     = 1'b0;
      m_mem    = 1'b0;
      m_branch = 1'b0;
      m_jump   = 1'b0;
    end
    m_taken = m_branch && branch_decision_i;
    if (m_mem) begin
      m_cycles = lat + 2;
    end else if (m_jump || m_taken) begin
      m_cycles = 2;
    end else begin
      m_cycles = 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h at %0t",
               test_name, what, expected, actual, $time);
    end
  endtask

  task automatic check_idle();
    check_equal("pc_set_o", 32'd0, 32'(pc_set_o));
    check_equal("lsu_o.req", 32'd0, 32'(lsu_o.req));
    check_equal("rf_we_o", 32'd0, 32'(rf_we_o));
    check_equal("instr_done_o", 32'd0, 32'(instr_done_o));
    check_equal("illegal_insn_o", 32'd0, 32'(illegal_insn_o));
  endtask

  task automatic check_cycle(input int c);
    logic done_exp;
    done_exp = (c == m_cycles);
    check_equal("instr_done_o", 32'(done_exp), 32'(instr_done_o));
    check_equal("rf_we_o", 32'(done_exp && m_we), 32'(rf_we_o));
    check_equal("pc_set_o", 32'((m_jump && c == 1) || (m_taken && c == 2)), 32'(pc_set_o));
    check_equal("lsu_o.req", 32'(m_mem && c == 1), 32'(lsu_o.req));
    check_equal("illegal_insn_o", 32'(m_illegal), 32'(illegal_insn_o));
    if (c == 1) begin
      check_equal("rf_raddr_a_o", 32'(instr_rdata_i[19:15]), 32'(rf_raddr_a_o));
      check_equal("rf_raddr_b_o", 32'(instr_rdata_i[24:20]), 32'(rf_raddr_b_o));
      check_equal("rf_waddr_o", 32'(instr_rdata_i[11:7]), 32'(rf_waddr_o));
      if (!m_illegal) begin
        check_equal("alu operator", 32'(m_op), 32'(alu_o.operator));
        check_equal("alu operand_a", m_a, alu_o.operand_a);
        check_equal("alu operand_b", m_b, alu_o.operand_b);
        if (m_mem) begin
          check_equal("lsu we", 32'(m_store), 32'(lsu_o.we));
          check_equal("lsu type", 32'(m_type), 32'(lsu_o.data_type));
          check_equal("lsu sign_ext", 32'(m_sext), 32'(lsu_o.sign_ext));
          check_equal("lsu wdata", rf_rdata_b_i, lsu_o.wdata);
        end
      end
    end else if (c == 2 && (m_jump || m_taken)) begin
      // Branch target or link value
      check_equal("alu operator", 32'(ALU_ADD), 32'(alu_o.operator));
      check_equal("alu operand_a", m_a2, alu_o.operand_a);
      check_equal("alu operand_b", m_b2, alu_o.operand_b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  function automatic string class_name(input int cls);
    case (cls)
      0:       return "op";
      1:       return "op_imm";
      2:       return "lui";
      3:       return "auipc";
      4:       return "load";
      5:       return "store";
      6:       return "branch";
      7:       return "jal";
      8:       return "jalr";
      default: return "random_opcode";
    endcase
  endfunction

  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    test_name         = "idle";
    instr_valid_i     = 1'b0;
    instr_rdata_i     = rand_bits(32);
    pc_id_i           = rand_bits(32);
    branch_decision_i = (rand_bits(1) != 0);
    lsu_valid_i       = 1'b0;
    @(negedge clk_i);
    check_idle();
  endtask

  task automatic run_instr();
    int         cls;
    int         lat;
    int         c;
    logic [1:0] f7_pick;
    logic       finished;
    word_t      instr;
    cls     = int'(rand_bits(4)) % 10;
    lat     = int'(rand_bits(3));
    f7_pick = 2'(rand_bits(2));
    instr   = rand_bits(32);
    // Bias funct7 towards the encodings that are legal
    if (f7_pick == 2'd0) begin
      instr[31:25] = 7'h00;
    end else if (f7_pick == 2'd1) begin
      instr[31:25] = 7'h20;
    end
    case (cls)
      0:       instr[6:0] = OPC_OP;
      1:       instr[6:0] = OPC_OP_IMM;
      2:       instr[6:0] = OPC_LUI;
      3:       instr[6:0] = OPC_AUIPC;
      4:       instr[6:0] = OPC_LOAD;
      5:       instr[6:0] = OPC_STORE;
      6:       instr[6:0] = OPC_BRANCH;
      7:       instr[6:0] = OPC_JAL;
      8:       instr[6:0] = OPC_JALR;
      default: instr[6:0] = instr[6:0];
    endcase
    @(posedge clk_i);
    #2;
    test_name         = class_name(cls);
    instr_valid_i     = 1'b1;
    instr_rdata_i     = instr;
    pc_id_i           = rand_bits(30) << 2;
    rf_rdata_a_i      = rand_bits(32);
    rf_rdata_b_i      = rand_bits(32);
    branch_decision_i = (rand_bits(1) != 0);
    lsu_valid_i       = 1'b0;
    predict_instr(lat);
    c        = 1;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      check_cycle(c);
      if (instr_done_o) begin
        finished = 1'b1;
      end else if (c >= MAX_INSTR_CYCLES) begin
        errors++;
        $display("Instruction %h (%s) did not complete within %0d cycles",
                 instr, test_name, c);
        finished = 1'b1;
      end else begin
        @(posedge clk_i);
        #2;
        c++;
        // Memory response pulse after the chosen latency
        lsu_valid_i = m_mem && (c == lat + 2);
      end
    end
  endtask

  initial begin
    int gap;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    lsu_valid_i       = 1'b0;
    test_name         = "reset";
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int n = 0; n < NUM_TRANS; n++) begin
      gap = int'(rand_bits(2)) % 3;
      repeat (gap) idle_cycle();
      run_instr();
    end
    idle_cycle();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_issue_ctrl.sv
logic/id_stage.sv
sim/tb_id_stage.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
